/* src/core_types_pkg.sv */
// shared sizes, op encodings, bus structs and writeback match helper
`default_nettype none

package core_types_pkg;

    // --------------------
    // sizes

    localparam int LOG_PR_COUNT       = 6;
    localparam int PR_COUNT           = 64;
    localparam int PRF_BANK_COUNT     = 4;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int UPPER_PR_WIDTH     = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;
    localparam int LOG_ROB_ENTRIES    = 5;
    localparam int IQ_DEPTH           = 8;

    typedef logic [LOG_PR_COUNT-1:0]       pr_t;
    typedef logic [UPPER_PR_WIDTH-1:0]     upper_pr_t;
    typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;
    typedef logic [LOG_ROB_ENTRIES-1:0]    rob_index_t;

    // --------------------
    // op encodings
    // alu ops follow {funct7[5], funct3}, mdu ops fill the unused codes
    typedef enum logic [3:0] {
        OP_ADD  = 4'b0000,
        OP_SLL  = 4'b0001,
        OP_SLT  = 4'b0010,
        OP_SLTU = 4'b0011,
        OP_XOR  = 4'b0100,
        OP_SRL  = 4'b0101,
        OP_OR   = 4'b0110,
        OP_AND  = 4'b0111,
        OP_SUB  = 4'b1000,
        OP_SRA  = 4'b1101,
        OP_MUL  = 4'b1010,
        OP_MULH = 4'b1011,
        OP_DIV  = 4'b1100,
        OP_REM  = 4'b1110
    } iq_op_t;

    // --------------------
    // structs

    // renamed op from dispatch
    typedef struct packed {
        logic       is_alu_reg;
        logic       is_mdu;
        iq_op_t     op;
        pr_t        A_PR;
        logic       A_is_zero;
        pr_t        B_PR;
        logic       B_is_zero;
        pr_t        dest_PR;
        rob_index_t ROB_index;
    } rename_op_t;

    // queue entry, op plus operand readiness
    typedef struct packed {
        rename_op_t rop;
        logic       A_ready;
        logic       B_ready;
    } iq_enq_t;

    // completing registers, one slot per prf bank
    typedef struct packed {
        logic [PRF_BANK_COUNT-1:0]            valid;
        upper_pr_t [PRF_BANK_COUNT-1:0]       upper_PR;
    } wb_bus_t;

    typedef struct packed {
        iq_op_t     op;
        logic       A_forward;
        logic       A_is_zero;
        pr_t        A_PR;
        logic       B_forward;
        logic       B_is_zero;
        pr_t        B_PR;
        pr_t        dest_PR;
        rob_index_t ROB_index;
    } issue_t;

    typedef struct packed {
        logic A_valid;
        pr_t  A_PR;
        logic B_valid;
        pr_t  B_PR;
    } prf_req_t;

    // register completes this cycle on its own bank
    function automatic logic wb_hit(pr_t pr, wb_bus_t wb);
        bank_t bank;
        bank = pr[LOG_PRF_BANK_COUNT-1:0];
        return wb.valid[bank] && (wb.upper_PR[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

endpackage

`default_nettype wire

/* src/pe_lsb.sv */
// lowest-set-bit priority encoder with one-hot grant and at-or-above mask
`default_nettype none
`timescale 1ns/1ps

module pe_lsb #(
    parameter int WIDTH = 8
) (
    input  wire logic [WIDTH-1:0] req_vec,
    output logic      [WIDTH-1:0] ack_one_hot,
    output logic      [WIDTH-1:0] ack_mask
);

    // set once the lowest request has been passed
    logic found;

    always_comb begin
        ack_one_hot = '0;
        ack_mask    = '0;
        found       = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            // first request wins
            if (req_vec[i] && !found) begin
                ack_one_hot[i] = 1'b1;
            end
            found       = found | req_vec[i];
            // granted bit and everything above it
            ack_mask[i] = found;
        end
    end

endmodule

`default_nettype wire

/* src/pr_ready_table.sv */
// per physical register ready bitmap with writeback set, alloc clear and bypass
`default_nettype none
`timescale 1ns/1ps

module pr_ready_table (
    input  wire logic                       CLK,
    input  wire logic                       nRST,

    // op being dispatched
    input  wire core_types_pkg::rename_op_t lookup_op,
    input  wire logic                       alloc_valid,

    // writeback by bank
    input  wire core_types_pkg::wb_bus_t    wb_bus,

    // source readiness for the dispatched op
    output logic                            A_ready,
    output logic                            B_ready
);
    import core_types_pkg::*;

    logic [PR_COUNT-1:0] ready_q;
    logic [PR_COUNT-1:0] set_vec;
    logic [PR_COUNT-1:0] clear_vec;

    // --------------------
    // strobe decode

    // each bank names one completing register
    always_comb begin
        set_vec = '0;
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            if (wb_bus.valid[b]) begin
                set_vec[{wb_bus.upper_PR[b], bank_t'(b)}] = 1'b1;
            end
        end
    end

    // new destination is not ready until written back
    always_comb begin
        clear_vec = '0;
        if (alloc_valid) begin
            clear_vec[lookup_op.dest_PR] = 1'b1;
        end
    end

    // --------------------
    // bitmap

    // clear after set, so allocation wins a same-cycle collision
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            ready_q <= '1;
        end else begin
            ready_q <= (ready_q | set_vec) & ~clear_vec;
        end
    end

    // --------------------
    // lookup

    // same-cycle writeback reads as ready
    always_comb begin
        A_ready = ready_q[lookup_op.A_PR] | set_vec[lookup_op.A_PR];
        B_ready = ready_q[lookup_op.B_PR] | set_vec[lookup_op.B_PR];
    end

endmodule

`default_nettype wire

/* src/alu_reg_mdu_iq.sv */
// compacting oldest-first alu reg / mdu issue queue with wakeup and prf read requests
`default_nettype none
`timescale 1ns/1ps

module alu_reg_mdu_iq #(
    parameter int IQ_ENTRIES = core_types_pkg::IQ_DEPTH
) (
    input  wire logic                     CLK,
    input  wire logic                     nRST,

    // enqueue from dispatch
    input  wire logic                     enq_valid,
    input  wire core_types_pkg::iq_enq_t  iq_enq,
    output logic                          enq_ready,

    // writeback by bank
    input  wire core_types_pkg::wb_bus_t  wb_bus,

    // pipeline feedback
    input  wire logic                     alu_reg_issue_ready,
    input  wire logic                     mdu_issue_ready,

    // issue to pipelines
    output logic                          alu_reg_issue_valid,
    output logic                          mdu_issue_valid,
    output core_types_pkg::issue_t        issue,

    // register read to prf
    output core_types_pkg::prf_req_t      prf_req
);
    import core_types_pkg::*;

    // entry state, index 0 is oldest
    logic    [IQ_ENTRIES-1:0] valid_q;
    iq_enq_t [IQ_ENTRIES-1:0] entry_q;
    logic    [IQ_ENTRIES-1:0] valid_d;
    iq_enq_t [IQ_ENTRIES-1:0] entry_d;

    // per-entry views
    logic [IQ_ENTRIES-1:0] is_alu_vec;
    logic [IQ_ENTRIES-1:0] is_mdu_vec;
    logic [IQ_ENTRIES-1:0] A_fwd;
    logic [IQ_ENTRIES-1:0] B_fwd;
    logic [IQ_ENTRIES-1:0] A_ok;
    logic [IQ_ENTRIES-1:0] B_ok;
    iq_enq_t  [IQ_ENTRIES-1:0] held_entry;
    issue_t   [IQ_ENTRIES-1:0] cand_issue;
    prf_req_t [IQ_ENTRIES-1:0] cand_req;

    // issue select
    logic [IQ_ENTRIES-1:0] issue_req;
    logic [IQ_ENTRIES-1:0] issue_one_hot;
    logic [IQ_ENTRIES-1:0] issue_mask;

    // dispatch slot select
    logic [IQ_ENTRIES-1:0] free_vec;
    logic [IQ_ENTRIES-1:0] free_one_hot;
    logic [IQ_ENTRIES-1:0] disp_one_hot;

    // what each slot sees one position up
    logic    [IQ_ENTRIES-1:0] above_valid;
    logic    [IQ_ENTRIES-1:0] above_disp;
    iq_enq_t [IQ_ENTRIES-1:0] above_entry;

    // --------------------
    // wakeup

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            is_alu_vec[i] = entry_q[i].rop.is_alu_reg;
            is_mdu_vec[i] = entry_q[i].rop.is_mdu;

            // match each operand against its own bank
            A_fwd[i] = wb_hit(entry_q[i].rop.A_PR, wb_bus);
            B_fwd[i] = wb_hit(entry_q[i].rop.B_PR, wb_bus);
            A_ok[i]  = entry_q[i].A_ready | A_fwd[i] | entry_q[i].rop.A_is_zero;
            B_ok[i]  = entry_q[i].B_ready | B_fwd[i] | entry_q[i].rop.B_is_zero;

            // forwards stick from the next edge on
            held_entry[i]         = entry_q[i];
            held_entry[i].A_ready = entry_q[i].A_ready | A_fwd[i];
            held_entry[i].B_ready = entry_q[i].B_ready | B_fwd[i];

            cand_issue[i].op        = entry_q[i].rop.op;
            cand_issue[i].A_forward = A_fwd[i];
            cand_issue[i].A_is_zero = entry_q[i].rop.A_is_zero;
            cand_issue[i].A_PR      = entry_q[i].rop.A_PR;
            cand_issue[i].B_forward = B_fwd[i];
            cand_issue[i].B_is_zero = entry_q[i].rop.B_is_zero;
            cand_issue[i].B_PR      = entry_q[i].rop.B_PR;
            cand_issue[i].dest_PR   = entry_q[i].rop.dest_PR;
            cand_issue[i].ROB_index = entry_q[i].rop.ROB_index;

            // read the prf only when the value is not on the bus or zero
            cand_req[i].A_valid = ~A_fwd[i] & ~entry_q[i].rop.A_is_zero;
            cand_req[i].A_PR    = entry_q[i].rop.A_PR;
            cand_req[i].B_valid = ~B_fwd[i] & ~entry_q[i].rop.B_is_zero;
            cand_req[i].B_PR    = entry_q[i].rop.B_PR;
        end
    end

    // --------------------
    // issue

    assign issue_req = valid_q & A_ok & B_ok
        & ((is_alu_vec & {IQ_ENTRIES{alu_reg_issue_ready}})
        | (is_mdu_vec & {IQ_ENTRIES{mdu_issue_ready}}));

    pe_lsb #(
        .WIDTH(IQ_ENTRIES)
    ) i_issue_pe (
        .req_vec    (issue_req),
        .ack_one_hot(issue_one_hot),
        .ack_mask   (issue_mask)
    );

    // single winner, so at most one pipeline sees valid
    assign alu_reg_issue_valid = |(issue_one_hot & is_alu_vec);
    assign mdu_issue_valid     = |(issue_one_hot & is_mdu_vec);

    // and-or mux, all zero when nothing wins
    always_comb begin
        issue   = '0;
        prf_req = '0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            issue   = issue_t'(issue | (cand_issue[i] & {$bits(issue_t){issue_one_hot[i]}}));
            prf_req = prf_req_t'(prf_req | (cand_req[i] & {$bits(prf_req_t){issue_one_hot[i]}}));
        end
    end

    // --------------------
    // dispatch

    assign free_vec = ~valid_q;

    pe_lsb #(
        .WIDTH(IQ_ENTRIES)
    ) i_free_pe (
        .req_vec    (free_vec),
        .ack_one_hot(free_one_hot),
        .ack_mask   ()
    );

    assign disp_one_hot = free_one_hot & {IQ_ENTRIES{enq_valid}};
    assign enq_ready    = |free_vec;

    // --------------------
    // compaction

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES - 1; i++) begin
            above_valid[i] = valid_q[i+1];
            above_disp[i]  = disp_one_hot[i+1];
            above_entry[i] = held_entry[i+1];
        end
        // nothing sits above the top slot
        above_valid[IQ_ENTRIES-1] = 1'b0;
        above_disp[IQ_ENTRIES-1]  = 1'b0;
        above_entry[IQ_ENTRIES-1] = iq_enq;
    end

    // shift down past the issued slot, else hold, else take the new op
    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (issue_mask[i]) begin
                valid_d[i] = above_valid[i] | above_disp[i];
                entry_d[i] = above_valid[i] ? above_entry[i] : iq_enq;
            end else begin
                valid_d[i] = valid_q[i] | disp_one_hot[i];
                entry_d[i] = valid_q[i] ? held_entry[i] : iq_enq;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge CLK) begin
        entry_q <= entry_d;
    end

endmodule

`default_nettype wire

/* src/alu_reg_mdu_issue_top.sv */
// integer issue top level joining the ready table and the alu reg / mdu queue
`default_nettype none
`timescale 1ns/1ps

module alu_reg_mdu_issue_top (
    input  wire logic                       CLK,
    input  wire logic                       nRST,

    // dispatch
    input  wire logic                       disp_valid,
    input  wire core_types_pkg::rename_op_t disp_op,
    output logic                            disp_ready,

    // writeback by bank
    input  wire core_types_pkg::wb_bus_t    wb_bus,

    // pipelines
    input  wire logic                       alu_reg_issue_ready,
    input  wire logic                       mdu_issue_ready,
    output logic                            alu_reg_issue_valid,
    output logic                            mdu_issue_valid,
    output core_types_pkg::issue_t          issue,
    output core_types_pkg::prf_req_t        prf_req
);
    import core_types_pkg::*;

    logic    alloc_valid;
    logic    A_ready;
    logic    B_ready;
    iq_enq_t iq_enq;

    // accepted dispatch claims its destination
    assign alloc_valid = disp_valid & disp_ready;
    assign iq_enq      = '{rop: disp_op, A_ready: A_ready, B_ready: B_ready};

    pr_ready_table i_ready_table (
        .CLK        (CLK),
        .nRST       (nRST),
        .lookup_op  (disp_op),
        .alloc_valid(alloc_valid),
        .wb_bus     (wb_bus),
        .A_ready    (A_ready),
        .B_ready    (B_ready)
    );

    alu_reg_mdu_iq #(
        .IQ_ENTRIES(IQ_DEPTH)
    ) i_iq (
        .CLK                (CLK),
        .nRST               (nRST),
        .enq_valid          (disp_valid),
        .iq_enq             (iq_enq),
        .enq_ready          (disp_ready),
        .wb_bus             (wb_bus),
        .alu_reg_issue_ready(alu_reg_issue_ready),
        .mdu_issue_ready    (mdu_issue_ready),
        .alu_reg_issue_valid(alu_reg_issue_valid),
        .mdu_issue_valid    (mdu_issue_valid),
        .issue              (issue),
        .prf_req            (prf_req)
    );

endmodule

`default_nettype wire

/* sim/tb_alu_reg_mdu_issue.sv */
// testbench for the integer issue top with a stimulus table and a reference queue model
`default_nettype none
`timescale 1ns/1ps

module tb_alu_reg_mdu_issue;
    import core_types_pkg::*;

    // one table row holds stimulus, the expected issue kind and disp_ready
    typedef struct packed {
        logic       dv;
        rename_op_t op;
        wb_bus_t    wb;
        logic [1:0] rdy;
        logic [1:0] exp_kind;
        logic       exp_drdy;
    } row_t;

    logic       CLK;
    logic       nRST;
    logic       disp_valid;
    rename_op_t disp_op;
    logic       disp_ready;
    wb_bus_t    wb_bus;
    logic       alu_reg_issue_ready;
    logic       mdu_issue_ready;
    logic       alu_reg_issue_valid;
    logic       mdu_issue_valid;
    issue_t     issue;
    prf_req_t   prf_req;

    string               row_names[$];
    row_t                rows[$];
    iq_enq_t             model_q[$];
    logic [PR_COUNT-1:0] model_ready;
    pr_t                 rand_dest;
    pr_t                 rand_src;
    int                  drain_cycles;
    logic                drained;

    alu_reg_mdu_issue_top i_dut (
        .CLK                (CLK),
        .nRST               (nRST),
        .disp_valid         (disp_valid),
        .disp_op            (disp_op),
        .disp_ready         (disp_ready),
        .wb_bus             (wb_bus),
        .alu_reg_issue_ready(alu_reg_issue_ready),
        .mdu_issue_ready    (mdu_issue_ready),
        .alu_reg_issue_valid(alu_reg_issue_valid),
        .mdu_issue_valid    (mdu_issue_valid),
        .issue              (issue),
        .prf_req            (prf_req)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // --------------------
    // helpers

    // scan every bank slot for the register
    function automatic logic completes(pr_t pr, wb_bus_t wb);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            if (wb.valid[b] && ({wb.upper_PR[b], bank_t'(b)} == pr)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic rename_op_t make_op(logic is_alu, iq_op_t code, pr_t a, pr_t b,
                                           pr_t dest, rob_index_t rob);
        rename_op_t op;
        op            = '0;
        op.is_alu_reg = is_alu;
        op.is_mdu     = ~is_alu;
        op.op         = code;
        op.A_PR       = a;
        op.B_PR       = b;
        op.dest_PR    = dest;
        op.ROB_index  = rob;
        return op;
    endfunction

    // writeback of a single register on its bank
    function automatic wb_bus_t bank_wb(pr_t pr);
        wb_bus_t wb;
        wb = '0;
        wb.valid[pr[LOG_PRF_BANK_COUNT-1:0]]    = 1'b1;
        wb.upper_PR[pr[LOG_PRF_BANK_COUNT-1:0]] = pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
        return wb;
    endfunction

    // rdy is {alu, mdu}, kind is {mdu valid, alu valid}
    task automatic add_row(input string name, input logic dv, input rename_op_t op,
                           input wb_bus_t wb, input logic [1:0] rdy,
                           input logic [1:0] kind, input logic drdy);
        row_t row;
        row.dv       = dv;
        row.op       = op;
        row.wb       = wb;
        row.rdy      = rdy;
        row.exp_kind = kind;
        row.exp_drdy = drdy;
        row_names.push_back(name);
        rows.push_back(row);
    endtask

    task automatic compare_field(input string name, input string what,
                                 input logic [63:0] exp_v, input logic [63:0] got_v);
        assert (exp_v == got_v) else begin
            $display("** Error: %s %s expected %0h actual %0h", name, what, exp_v, got_v);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // --------------------
    // reference model

    task automatic check_cycle(input string name);
        iq_enq_t  e;
        iq_enq_t  fresh;
        issue_t   exp_issue;
        prf_req_t exp_req;
        logic     a_fwd;
        logic     b_fwd;
        logic     exp_alu;
        logic     exp_mdu;
        logic     exp_drdy;
        int       pick;

        exp_issue = '0;
        exp_req   = '0;
        exp_alu   = 1'b0;
        exp_mdu   = 1'b0;
        pick      = -1;
        // oldest entry with both operands available and its pipeline open
        for (int i = 0; i < model_q.size(); i++) begin
            e = model_q[i];
            if (pick < 0
                && (e.A_ready || e.rop.A_is_zero || completes(e.rop.A_PR, wb_bus))
                && (e.B_ready || e.rop.B_is_zero || completes(e.rop.B_PR, wb_bus))
                && ((e.rop.is_alu_reg && alu_reg_issue_ready)
                    || (e.rop.is_mdu && mdu_issue_ready))) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            e                   = model_q[pick];
            a_fwd               = completes(e.rop.A_PR, wb_bus);
            b_fwd               = completes(e.rop.B_PR, wb_bus);
            exp_alu             = e.rop.is_alu_reg;
            exp_mdu             = e.rop.is_mdu;
            exp_issue.op        = e.rop.op;
            exp_issue.A_forward = a_fwd;
            exp_issue.A_is_zero = e.rop.A_is_zero;
            exp_issue.A_PR      = e.rop.A_PR;
            exp_issue.B_forward = b_fwd;
            exp_issue.B_is_zero = e.rop.B_is_zero;
            exp_issue.B_PR      = e.rop.B_PR;
            exp_issue.dest_PR   = e.rop.dest_PR;
            exp_issue.ROB_index = e.rop.ROB_index;
            exp_req.A_valid     = !a_fwd && !e.rop.A_is_zero;
            exp_req.A_PR        = e.rop.A_PR;
            exp_req.B_valid     = !b_fwd && !e.rop.B_is_zero;
            exp_req.B_PR        = e.rop.B_PR;
        end
        exp_drdy = (model_q.size() < IQ_DEPTH);

        compare_field(name, "alu_reg_issue_valid", 64'(exp_alu), 64'(alu_reg_issue_valid));
        compare_field(name, "mdu_issue_valid", 64'(exp_mdu), 64'(mdu_issue_valid));
        compare_field(name, "disp_ready", 64'(exp_drdy), 64'(disp_ready));
        compare_field(name, "issue", 64'(exp_issue), 64'(issue));
        compare_field(name, "prf_req", 64'(exp_req), 64'(prf_req));

        // state at the next edge, with lookup bypassing this cycle's writeback
        fresh.rop     = disp_op;
        fresh.A_ready = model_ready[disp_op.A_PR] | completes(disp_op.A_PR, wb_bus);
        fresh.B_ready = model_ready[disp_op.B_PR] | completes(disp_op.B_PR, wb_bus);
        if (pick >= 0) begin
            model_q.delete(pick);
        end
        for (int i = 0; i < model_q.size(); i++) begin
            e         = model_q[i];
            e.A_ready = e.A_ready | completes(e.rop.A_PR, wb_bus);
            e.B_ready = e.B_ready | completes(e.rop.B_PR, wb_bus);
            model_q[i] = e;
        end
        if (disp_valid && exp_drdy) begin
            model_q.push_back(fresh);
        end
        for (int p = 0; p < PR_COUNT; p++) begin
            if (completes(pr_t'(p), wb_bus)) begin
                model_ready[p] = 1'b1;
            end
        end
        // allocation after writeback so it wins a collision
        if (disp_valid && exp_drdy) begin
            model_ready[disp_op.dest_PR] = 1'b0;
        end
    endtask

    // --------------------
    // stimulus table

    task automatic build_table();
        rename_op_t op;
        rename_op_t idle;
        rename_op_t full_op;
        iq_op_t     code;
        logic       is_alu;

        idle = make_op(1'b1, OP_ADD, 0, 0, 0, 0);
        add_row("b1_fill_add", 1'b1, make_op(1'b1, OP_ADD, 1, 2, 10, 0), '0, 2'b00, 2'd0, 1'b1);
        add_row("b1_fill_mul", 1'b1, make_op(1'b0, OP_MUL, 3, 4, 11, 1), '0, 2'b00, 2'd0, 1'b1);
        add_row("b1_fill_xor", 1'b1, make_op(1'b1, OP_XOR, 5, 6, 12, 2), '0, 2'b00, 2'd0, 1'b1);
        add_row("b1_issue_add", 1'b0, idle, '0, 2'b11, 2'd1, 1'b1);
        add_row("b1_issue_mul", 1'b0, idle, '0, 2'b11, 2'd2, 1'b1);
        add_row("b1_issue_xor", 1'b0, idle, '0, 2'b11, 2'd1, 1'b1);
        add_row("b1_empty", 1'b0, idle, '0, 2'b11, 2'd0, 1'b1);

        // consumers of a fresh destination wait for its writeback
        add_row("b2_producer", 1'b1, make_op(1'b0, OP_DIV, 1, 2, 20, 3), '0, 2'b11, 2'd0, 1'b1);
        add_row("b2_consumer", 1'b1, make_op(1'b1, OP_ADD, 20, 1, 21, 4), '0, 2'b11, 2'd2, 1'b1);
        op = make_op(1'b0, OP_MUL, 3, 20, 29, 22);
        add_row("b2_wait", 1'b1, op, '0, 2'b11, 2'd0, 1'b1);
        add_row("b2_wakeup", 1'b0, idle, bank_wb(20), 2'b11, 2'd1, 1'b1);
        // the younger mul saw the same writeback and holds it
        add_row("b2_latched", 1'b0, idle, '0, 2'b11, 2'd2, 1'b1);

        // only the zero flag lets these go while register 21 is pending
        op           = make_op(1'b1, OP_OR, 21, 2, 22, 5);
        op.A_is_zero = 1'b1;
        add_row("b3_zero_a", 1'b1, op, '0, 2'b11, 2'd0, 1'b1);
        op           = make_op(1'b1, OP_SLT, 0, 21, 23, 6);
        op.A_is_zero = 1'b1;
        op.B_is_zero = 1'b1;
        add_row("b3_zero_ab", 1'b1, op, '0, 2'b11, 2'd1, 1'b1);
        add_row("b3_issue_slt", 1'b1, make_op(1'b1, OP_SLL, 1, 2, 24, 7), '0, 2'b11, 2'd1, 1'b1);

        // mdu ops go around the stalled alu pipeline
        add_row("b4_mulh", 1'b1, make_op(1'b0, OP_MULH, 3, 4, 25, 8), '0, 2'b01, 2'd0, 1'b1);
        add_row("b4_sra", 1'b1, make_op(1'b1, OP_SRA, 5, 6, 26, 9), '0, 2'b01, 2'd2, 1'b1);
        add_row("b4_rem", 1'b1, make_op(1'b0, OP_REM, 1, 3, 27, 10), '0, 2'b01, 2'd0, 1'b1);
        add_row("b4_pass_rem", 1'b0, idle, '0, 2'b01, 2'd2, 1'b1);
        add_row("b4_release_sll", 1'b0, idle, '0, 2'b11, 2'd1, 1'b1);
        add_row("b4_release_sra", 1'b0, idle, '0, 2'b11, 2'd1, 1'b1);

        op = make_op(1'b0, OP_MUL, 1, 2, rand_dest, 11);
        add_row("b5_producer", 1'b1, op, '0, 2'b11, 2'd0, 1'b1);
        op = make_op(1'b1, OP_AND, rand_src, rand_dest, 28, 12);
        add_row("b5_consumer", 1'b1, op, bank_wb(rand_dest), 2'b10, 2'd0, 1'b1);
        add_row("b5_issue", 1'b0, idle, '0, 2'b10, 2'd1, 1'b1);
        add_row("b5_mdu", 1'b0, idle, '0, 2'b11, 2'd2, 1'b1);

        for (int i = 0; i < IQ_DEPTH; i++) begin
            is_alu = (i % 2 == 0);
            code   = is_alu ? OP_ADD : OP_MUL;
            op     = make_op(is_alu, code, 1, 2, pr_t'(30 + i), rob_index_t'(13 + i));
            add_row("b6_fill", 1'b1, op, '0, 2'b00, 2'd0, 1'b1);
        end
        full_op = make_op(1'b1, OP_SUB, 1, 2, 38, 21);
        add_row("b6_full", 1'b1, full_op, '0, 2'b00, 2'd0, 1'b0);
        add_row("b6_issue_one", 1'b1, full_op, '0, 2'b11, 2'd1, 1'b0);
        add_row("b6_room", 1'b1, full_op, '0, 2'b00, 2'd0, 1'b1);
    endtask

    // --------------------
    // main sequence

    initial begin
        nRST                = 1'b0;
        disp_valid          = 1'b0;
        disp_op             = '0;
        wb_bus              = '0;
        alu_reg_issue_ready = 1'b0;
        mdu_issue_ready     = 1'b0;
        model_ready         = '1;
        drained             = 1'b0;
        drain_cycles        = 0;

        void'($urandom(32'h4fa2c65f));
        // pending producer and an always ready source outside the table's registers
        rand_dest = pr_t'(48 + $urandom % 8);
        rand_src  = pr_t'(56 + $urandom % 8);
        build_table();

        repeat (3) @(posedge CLK);
        nRST <= 1'b1;

        for (int r = 0; r < rows.size(); r++) begin
            @(posedge CLK);
            disp_valid          <= rows[r].dv;
            disp_op             <= rows[r].op;
            wb_bus              <= rows[r].wb;
            alu_reg_issue_ready <= rows[r].rdy[1];
            mdu_issue_ready     <= rows[r].rdy[0];
            @(negedge CLK);
            compare_field(row_names[r], "issue kind", 64'(rows[r].exp_kind),
                          64'({mdu_issue_valid, alu_reg_issue_valid}));
            compare_field(row_names[r], "table disp_ready", 64'(rows[r].exp_drdy),
                          64'(disp_ready));
            check_cycle(row_names[r]);
        end

        // drain with both pipelines open for at most 20 cycles
        while (!drained && drain_cycles < 20) begin
            @(posedge CLK);
            disp_valid          <= 1'b0;
            wb_bus              <= '0;
            alu_reg_issue_ready <= 1'b1;
            mdu_issue_ready     <= 1'b1;
            @(negedge CLK);
            check_cycle("drain");
            drained = (model_q.size() == 0) && !alu_reg_issue_valid && !mdu_issue_valid;
            drain_cycles++;
        end

        if (!drained) begin
            $display("timeout: queue still issuing after %0d drain cycles", drain_cycles);
            $display("TB FAILED");
            $fatal(1, "drain timeout");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
src/core_types_pkg.sv
src/pe_lsb.sv
src/pr_ready_table.sv
src/alu_reg_mdu_iq.sv
src/alu_reg_mdu_issue_top.sv
sim/tb_alu_reg_mdu_issue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the issue subsystem testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

TOP=tb_alu_reg_mdu_issue
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module "$TOP" --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
exit 0
